// ==== hdl/mcont_types_pkg.sv ====
// data and width types shared by the write-data path and its testbench
// the channel number is 4 bits wide, so no more than 16 channels fit
`default_nettype none

package mcont_types_pkg;

    // width of one data word in the buffers and on the stream
    localparam int DATA_W = 64;

    // address bits inside one channel buffer
    localparam int ADDR_W = 8;

    // width of the shared channel select and of the stream channel tag
    localparam int CHN_W = 4;

    // words per channel buffer, one full address range
    localparam int BUF_DEPTH = 1 << ADDR_W;

    // one buffered or streamed data word
    typedef logic [DATA_W-1:0] buf_data_t;

    // word address inside a channel buffer
    typedef logic [ADDR_W-1:0] buf_addr_t;

    // channel number as carried on ext_buf_rchn and wdata_chn
    typedef logic [CHN_W-1:0] chn_num_t;

endpackage

`default_nettype wire

// ==== hdl/mcont_seq_pkg.sv ====
// sequencer states and command field types
// a burst length field holds the word count minus one
`default_nettype none

package mcont_seq_pkg;

    // burst length as given with cmd_start, 0 means one word and 255 means 256
    typedef logic [7:0] burst_len_t;

    // sequencer states, busy is reported in every state but st_idle
    typedef enum logic [1:0] {
        st_idle    = 2'd0,  // waiting for a start or refresh strobe
        st_select  = 2'd1,  // channel select settles one cycle ahead of the reads
        st_read    = 2'd2,  // one read pulse per word
        st_refresh = 2'd3   // path held idle while the memory refreshes
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/mcont_from_chnbuf_reg.sv ====
// per-channel registering stage between a channel buffer and the shared read bus
// ext_buf_rchn has to be valid one cycle before the first ext_buf_rd of a burst
`timescale 1ns/1ns
`default_nettype none

module mcont_from_chnbuf_reg #(
    parameter int CHN_NUMBER  = 0,  // index of this channel on the shared select
    parameter int CHN_LATENCY = 1   // extra buffer read latency, 0 or 1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       ext_buf_rd,       // shared read pulse, one per word
    input  wire mcont_types_pkg::chn_num_t  ext_buf_rchn,     // channel being read
    input  wire logic                       ext_buf_rrefresh, // refresh in progress
    input  wire logic                       ext_buf_rrun,     // read state of the sequencer
    input  wire mcont_types_pkg::buf_data_t buf_rdata_chn,    // word from this channel's buffer
    output mcont_types_pkg::buf_data_t      ext_buf_rdata,    // captured word for the gatherer
    output logic                            buf_rd_chn,       // read enable to the buffer
    output logic                            buf_run           // buffer read address runs while high
);

    localparam int SR_W = CHN_LATENCY + 1;

    logic            chn_match;  // select decode before registering
    logic            chn_sel;    // registered select, one cycle behind ext_buf_rchn
    logic [SR_W-1:0] lat_sr;     // follows each read until the buffer word is valid

    // a refresh masks the channel so no read or run can leak through
    assign chn_match = (ext_buf_rchn == mcont_types_pkg::chn_num_t'(CHN_NUMBER)) &&
                       !ext_buf_rrefresh;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chn_sel    <= 1'b0;
            buf_rd_chn <= 1'b0;
            buf_run    <= 1'b0;
            lat_sr     <= '0;
        end else begin
            chn_sel    <= chn_match;
            buf_rd_chn <= chn_sel && ext_buf_rd;  // the select has had its cycle to settle
            buf_run    <= chn_match && ext_buf_rrun;
            lat_sr     <= (lat_sr << 1) | SR_W'(buf_rd_chn);
        end
    end

    // the last shifter stage lines up with the buffer output of that read
    always_ff @(posedge clk) begin
        if (lat_sr[CHN_LATENCY]) ext_buf_rdata <= buf_rdata_chn;
    end

endmodule

`default_nettype wire

// ==== hdl/chn_write_buffer.sv ====
// one channel's write-data buffer, host writes on one port and burst reads on the other
// the host must not write a channel while that channel is being read
`timescale 1ns/1ns
`default_nettype none

module chn_write_buffer #(
    parameter int CHN_LATENCY = 1  // 1 adds an output register after the read port
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       we,            // host write strobe for this channel
    input  wire mcont_types_pkg::buf_addr_t waddr,         // host write address
    input  wire mcont_types_pkg::buf_data_t wdata,         // host write data
    input  wire logic                       buf_rd_chn,    // one read per word
    input  wire logic                       buf_run,       // low clears the read address
    output mcont_types_pkg::buf_data_t      buf_rdata_chn  // word out, CHN_LATENCY+1 after the read
);

    mcont_types_pkg::buf_data_t mem [mcont_types_pkg::BUF_DEPTH];

    mcont_types_pkg::buf_addr_t raddr;    // read address of the running burst
    mcont_types_pkg::buf_data_t rdata_r;  // registered read port

    // host side write port
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // every burst starts from address 0 because buf_run drops between bursts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raddr <= '0;
        end else if (!buf_run) begin
            raddr <= '0;
        end else if (buf_rd_chn) begin
            raddr <= raddr + 1'b1;  // wraps after the last word of a full 256-word burst
        end
    end

    // the read uses the address before it advances
    always_ff @(posedge clk) begin
        if (buf_rd_chn) rdata_r <= mem[raddr];
    end

    generate
        if (CHN_LATENCY == 1) begin : g_out_reg
            mcont_types_pkg::buf_data_t rdata_q;  // extra stage, like a block RAM output register

            always_ff @(posedge clk) begin
                rdata_q <= rdata_r;
            end

            assign buf_rdata_chn = rdata_q;
        end else begin : g_no_out_reg
            assign buf_rdata_chn = rdata_r;  // word valid the cycle after the read enable
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/mcont_write_sequencer.sv ====
// turns burst and refresh strobes into the shared read strobes of all channels
// strobes that arrive while busy are dropped, and a refresh wins over a start
`timescale 1ns/1ns
`default_nettype none

module mcont_write_sequencer #(
    parameter int REFRESH_CYCLES = 8  // refresh length in cycles, at least 1
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         cmd_start,        // one-cycle burst request
    input  wire mcont_types_pkg::chn_num_t    cmd_chn,          // channel of the burst
    input  wire mcont_seq_pkg::burst_len_t    cmd_len,          // words in the burst minus one
    input  wire logic                         cmd_refresh,      // one-cycle refresh request
    output logic                              busy,             // high in every state but idle
    output logic                              refresh_active,   // refresh status for the host
    output logic                              ext_buf_rd,       // one pulse per word
    output logic                              ext_buf_rrun,     // high for the whole read state
    output logic                              ext_buf_rrefresh, // masks all channel selects
    output mcont_types_pkg::chn_num_t         ext_buf_rchn      // held for the whole command
);

    // counter wide enough to hold REFRESH_CYCLES - 1
    localparam int REF_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;

    mcont_seq_pkg::seq_state_t state;
    mcont_seq_pkg::burst_len_t word_cnt;  // words left after the current one
    logic [REF_W-1:0]          ref_cnt;   // refresh cycles left after the current one

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= mcont_seq_pkg::st_idle;
            word_cnt     <= '0;
            ref_cnt      <= '0;
            ext_buf_rchn <= '0;
        end else begin
            case (state)
                mcont_seq_pkg::st_idle: begin
                    if (cmd_refresh) begin
                        ref_cnt <= REF_W'(REFRESH_CYCLES - 1);
                        state   <= mcont_seq_pkg::st_refresh;
                    end else if (cmd_start) begin
                        ext_buf_rchn <= cmd_chn;  // select goes out one cycle ahead of the reads
                        word_cnt     <= cmd_len;
                        state        <= mcont_seq_pkg::st_select;
                    end
                end

                // the channel registers decode the new select during this cycle
                mcont_seq_pkg::st_select: begin
                    state <= mcont_seq_pkg::st_read;
                end

                mcont_seq_pkg::st_read: begin
                    if (word_cnt == '0) begin
                        state <= mcont_seq_pkg::st_idle;  // last word was read this cycle
                    end else begin
                        word_cnt <= word_cnt - 1'b1;
                    end
                end

                mcont_seq_pkg::st_refresh: begin
                    if (ref_cnt == '0) begin
                        state <= mcont_seq_pkg::st_idle;
                    end else begin
                        ref_cnt <= ref_cnt - 1'b1;
                    end
                end

                default: begin
                    state <= mcont_seq_pkg::st_idle;  // unused encodings fall back to idle
                end
            endcase
        end
    end

    // all outputs decode straight from the state register so they have no extra delay
    always_comb begin
        busy             = (state != mcont_seq_pkg::st_idle);
        refresh_active   = (state == mcont_seq_pkg::st_refresh);
        ext_buf_rrefresh = (state == mcont_seq_pkg::st_refresh);
        ext_buf_rrun     = (state == mcont_seq_pkg::st_read);
        // reads run without gaps, so the pulse train matches the run level here
        ext_buf_rd       = (state == mcont_seq_pkg::st_read);
    end

endmodule

`default_nettype wire

// ==== hdl/mcont_wdata_gather.sv ====
// collects the captured words of all channels into one registered write-data stream
// there is no back-pressure, the stream has to be taken on every valid cycle
`timescale 1ns/1ns
`default_nettype none

module mcont_wdata_gather #(
    parameter int CHN_LATENCY = 1,  // extra buffer read latency, 0 or 1
    parameter int NUM_CHN     = 4   // channel count
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       ext_buf_rd,          // shared read pulse
    input  wire mcont_types_pkg::chn_num_t  ext_buf_rchn,        // channel of that read
    input  wire mcont_types_pkg::buf_data_t chn_rdata [NUM_CHN], // captured word per channel
    output mcont_types_pkg::buf_data_t      wdata,
    output logic                            wdata_valid,
    output mcont_types_pkg::chn_num_t       wdata_chn
);

    // read pulse to ext_buf_rdata takes 3 + CHN_LATENCY cycles
    localparam int PIPE_D = 3 + CHN_LATENCY;

    logic [PIPE_D-1:0]          rd_pipe;            // one bit per word in flight
    mcont_types_pkg::chn_num_t  chn_pipe [PIPE_D];  // channel tag travelling with each bit
    mcont_types_pkg::buf_data_t sel_word;           // word of the channel at the pipe end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pipe     <= '0;
            wdata_valid <= 1'b0;
        end else begin
            rd_pipe     <= {rd_pipe[PIPE_D-2:0], ext_buf_rd};
            wdata_valid <= rd_pipe[PIPE_D-1];
        end
    end

    // channel tags move beside the read bits, and the last tag picks the word for the stream
    always_ff @(posedge clk) begin
        chn_pipe[0] <= ext_buf_rchn;
        for (int k = 1; k < PIPE_D; k++) begin
            chn_pipe[k] <= chn_pipe[k-1];
        end
        wdata     <= sel_word;
        wdata_chn <= chn_pipe[PIPE_D-1];
    end

    // channel mux, a tag beyond NUM_CHN gives a zero word
    always_comb begin
        sel_word = '0;
        for (int i = 0; i < NUM_CHN; i++) begin
            if (chn_pipe[PIPE_D-1] == mcont_types_pkg::chn_num_t'(i)) sel_word = chn_rdata[i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mcont_wpath_top.sv ====
// write-data path with NUM_CHN host-filled buffers, one burst sequencer and one stream out
// NUM_CHN goes up to 16 and CHN_LATENCY is 0 or 1
`timescale 1ns/1ns
`default_nettype none

module mcont_wpath_top #(
    parameter int NUM_CHN        = 4,  // channel count
    parameter int CHN_LATENCY    = 1,  // extra buffer read latency
    parameter int REFRESH_CYCLES = 8   // refresh length in cycles
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // host write side
    input  wire logic                       host_we,
    input  wire mcont_types_pkg::chn_num_t  host_chn,
    input  wire mcont_types_pkg::buf_addr_t host_waddr,
    input  wire mcont_types_pkg::buf_data_t host_wdata,
    // commands, honoured only while busy is low
    input  wire logic                       cmd_start,
    input  wire mcont_types_pkg::chn_num_t  cmd_chn,
    input  wire mcont_seq_pkg::burst_len_t  cmd_len,
    input  wire logic                       cmd_refresh,
    // status
    output logic                            busy,
    output logic                            refresh_active,
    output logic [NUM_CHN-1:0]              chn_run,
    // write-data stream
    output mcont_types_pkg::buf_data_t      wdata,
    output logic                            wdata_valid,
    output mcont_types_pkg::chn_num_t       wdata_chn
);

    // shared strobes from the sequencer to every channel
    logic                       ext_buf_rd;
    logic                       ext_buf_rrun;
    logic                       ext_buf_rrefresh;
    mcont_types_pkg::chn_num_t  ext_buf_rchn;

    // per channel links
    logic [NUM_CHN-1:0]         chn_we;         // decoded host write strobes
    logic [NUM_CHN-1:0]         buf_rd_chn;
    logic [NUM_CHN-1:0]         buf_run;
    mcont_types_pkg::buf_data_t buf_rdata_chn [NUM_CHN];
    mcont_types_pkg::buf_data_t ext_buf_rdata [NUM_CHN];

    mcont_write_sequencer #(
        .REFRESH_CYCLES(REFRESH_CYCLES)
    ) u_seq (
        .clk             (clk),
        .rst             (rst),
        .cmd_start       (cmd_start),
        .cmd_chn         (cmd_chn),
        .cmd_len         (cmd_len),
        .cmd_refresh     (cmd_refresh),
        .busy            (busy),
        .refresh_active  (refresh_active),
        .ext_buf_rd      (ext_buf_rd),
        .ext_buf_rrun    (ext_buf_rrun),
        .ext_buf_rrefresh(ext_buf_rrefresh),
        .ext_buf_rchn    (ext_buf_rchn)
    );

    generate
        for (genvar i = 0; i < NUM_CHN; i++) begin : g_chn
            assign chn_we[i] = host_we && (host_chn == mcont_types_pkg::chn_num_t'(i));

            chn_write_buffer #(
                .CHN_LATENCY(CHN_LATENCY)
            ) u_buf (
                .clk          (clk),
                .rst          (rst),
                .we           (chn_we[i]),
                .waddr        (host_waddr),
                .wdata        (host_wdata),
                .buf_rd_chn   (buf_rd_chn[i]),
                .buf_run      (buf_run[i]),
                .buf_rdata_chn(buf_rdata_chn[i])
            );

            mcont_from_chnbuf_reg #(
                .CHN_NUMBER (i),
                .CHN_LATENCY(CHN_LATENCY)
            ) u_reg (
                .clk             (clk),
                .rst             (rst),
                .ext_buf_rd      (ext_buf_rd),
                .ext_buf_rchn    (ext_buf_rchn),
                .ext_buf_rrefresh(ext_buf_rrefresh),
                .ext_buf_rrun    (ext_buf_rrun),
                .buf_rdata_chn   (buf_rdata_chn[i]),
                .ext_buf_rdata   (ext_buf_rdata[i]),
                .buf_rd_chn      (buf_rd_chn[i]),
                .buf_run         (buf_run[i])
            );
        end
    endgenerate

    assign chn_run = buf_run;  // a channel runs exactly while its read address is live

    mcont_wdata_gather #(
        .CHN_LATENCY(CHN_LATENCY),
        .NUM_CHN    (NUM_CHN)
    ) u_gather (
        .clk         (clk),
        .rst         (rst),
        .ext_buf_rd  (ext_buf_rd),
        .ext_buf_rchn(ext_buf_rchn),
        .chn_rdata   (ext_buf_rdata),
        .wdata       (wdata),
        .wdata_valid (wdata_valid),
        .wdata_chn   (wdata_chn)
    );

endmodule

`default_nettype wire

// ==== verif/mcont_wpath_tb.sv ====
// directed testbench for the write-data path with four channels and default timing
// expected stream and status timing assume CHN_LATENCY 1 and REFRESH_CYCLES 8
`timescale 1ns/1ns
`default_nettype none

module mcont_wpath_tb;

    localparam int NUM_CHN        = 4;
    localparam int CHN_LATENCY    = 1;
    localparam int REFRESH_CYCLES = 8;
    localparam int CYCLE_LIMIT    = 20000;             // about ten times the whole test length
    localparam int STREAM_DELAY   = 6 + CHN_LATENCY;  // start strobe to the first valid word

    logic                       clk;
    logic                       rst;
    logic                       host_we;
    mcont_types_pkg::chn_num_t  host_chn;
    mcont_types_pkg::buf_addr_t host_waddr;
    mcont_types_pkg::buf_data_t host_wdata;
    logic                       cmd_start;
    mcont_types_pkg::chn_num_t  cmd_chn;
    mcont_seq_pkg::burst_len_t  cmd_len;
    logic                       cmd_refresh;
    logic                       busy;
    logic                       refresh_active;
    logic [NUM_CHN-1:0]         chn_run;
    mcont_types_pkg::buf_data_t wdata;
    logic                       wdata_valid;
    mcont_types_pkg::chn_num_t  wdata_chn;

    // reference copy of every word the host has written
    mcont_types_pkg::buf_data_t mirror [NUM_CHN][mcont_types_pkg::BUF_DEPTH];

    int                         cyc = 0;     // posedges since time 0
    int                         exp_cyc [$];  // cycle each expected word must show up
    mcont_types_pkg::buf_data_t exp_data [$];
    mcont_types_pkg::chn_num_t  exp_chn [$];
    int                         busy_from;    // busy and refresh are expected inside these spans
    int                         busy_to;
    int                         ref_from;
    int                         ref_to;
    int                         run_from [NUM_CHN];
    int                         run_to [NUM_CHN];

    mcont_wpath_top #(
        .NUM_CHN       (NUM_CHN),
        .CHN_LATENCY   (CHN_LATENCY),
        .REFRESH_CYCLES(REFRESH_CYCLES)
    ) DUT (
        .clk(clk), .rst(rst),
        .host_we(host_we), .host_chn(host_chn), .host_waddr(host_waddr), .host_wdata(host_wdata),
        .cmd_start(cmd_start), .cmd_chn(cmd_chn), .cmd_len(cmd_len), .cmd_refresh(cmd_refresh),
        .busy(busy), .refresh_active(refresh_active), .chn_run(chn_run),
        .wdata(wdata), .wdata_valid(wdata_valid), .wdata_chn(wdata_chn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(string name, mcont_types_pkg::buf_data_t got,
                              mcont_types_pkg::buf_data_t want);
        if (got !== want) begin
            $display("[ERROR] %s at cycle %0d: got 0x%h, expected 0x%h", name, cyc, got, want);
            abort_run();
        end
    endtask

    task automatic check_chn(string name, mcont_types_pkg::chn_num_t got,
                             mcont_types_pkg::chn_num_t want);
        if (got !== want) begin
            $display("[ERROR] %s at cycle %0d: got 0x%h, expected 0x%h", name, cyc, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic want);
        if (got !== want) begin
            $display("[ERROR] %s at cycle %0d: got 0x%h, expected 0x%h", name, cyc, got, want);
            abort_run();
        end
    endtask

    function automatic logic in_span(int c, int lo, int hi);
        return (c >= lo) && (c <= hi);
    endfunction

    // one clock cycle, then every output is compared with the model at the falling edge
    task automatic step();
        logic want_valid;
        @(negedge clk);
        want_valid = 1'b0;
        if (exp_cyc.size() > 0) want_valid = (exp_cyc[0] == cyc);  // words come in issue order
        check_bit("wdata_valid", wdata_valid, want_valid);
        if (want_valid) begin
            check_data("wdata", wdata, exp_data[0]);
            check_chn("wdata_chn", wdata_chn, exp_chn[0]);
            void'(exp_cyc.pop_front());
            void'(exp_data.pop_front());
            void'(exp_chn.pop_front());
        end
        check_bit("busy", busy, in_span(cyc, busy_from, busy_to));
        check_bit("refresh_active", refresh_active, in_span(cyc, ref_from, ref_to));
        for (int c = 0; c < NUM_CHN; c++) begin
            check_bit($sformatf("chn_run[%0d]", c), chn_run[c],
                      in_span(cyc, run_from[c], run_to[c]));
        end
    endtask

    task automatic fill_channel(int chn);
        mcont_types_pkg::buf_data_t word;
        for (int a = 0; a < mcont_types_pkg::BUF_DEPTH; a++) begin
            word       = {$urandom, $urandom};
            host_we    = 1'b1;
            host_chn   = mcont_types_pkg::chn_num_t'(chn);
            host_waddr = mcont_types_pkg::buf_addr_t'(a);
            host_wdata = word;
            mirror[chn][a] = word;
            step();  // the word lands at the rising edge inside this step
        end
        host_we = 1'b0;
    endtask

    // strobe goes out on the current cycle s, the model spans follow from s
    task automatic start_burst(int chn, int len);
        int s;
        s         = cyc;
        cmd_start = 1'b1;
        cmd_chn   = mcont_types_pkg::chn_num_t'(chn);
        cmd_len   = mcont_seq_pkg::burst_len_t'(len);
        busy_from = s + 1;        // select cycle
        busy_to   = s + 2 + len;  // last read
        run_from[chn] = s + 3;
        run_to[chn]   = s + 3 + len;
        for (int i = 0; i <= len; i++) begin
            exp_cyc.push_back(s + STREAM_DELAY + i);  // every burst reads from address 0
            exp_data.push_back(mirror[chn][i]);
            exp_chn.push_back(mcont_types_pkg::chn_num_t'(chn));
        end
        step();
        cmd_start = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) step();  // returns on the first cycle the sequencer is idle again
    endtask

    task automatic drain_stream();
        while (exp_cyc.size() > 0) step();
    endtask

    task automatic run_burst(int chn, int len);
        start_burst(chn, len);
        wait_idle();
    endtask

    // the spans make step compare busy and refresh_active on every cycle of the refresh
    task automatic run_refresh();
        cmd_refresh = 1'b1;
        busy_from   = cyc + 1;
        busy_to     = cyc + REFRESH_CYCLES;
        ref_from    = cyc + 1;
        ref_to      = cyc + REFRESH_CYCLES;
        step();
        cmd_refresh = 1'b0;
        wait_idle();
    endtask

    task automatic test_reset_state();
        step();
        check_bit("busy", busy, 1'b0);
        check_bit("refresh_active", refresh_active, 1'b0);
        check_bit("wdata_valid", wdata_valid, 1'b0);
        for (int c = 0; c < NUM_CHN; c++) begin
            check_bit($sformatf("chn_run[%0d]", c), chn_run[c], 1'b0);
        end
    endtask

    task automatic test_single_burst();
        fill_channel(0);
        run_burst(0, 15);  // 16 words
        drain_stream();
    endtask

    task automatic test_all_channels();
        for (int c = 0; c < NUM_CHN; c++) fill_channel(c);
        for (int c = 0; c < NUM_CHN; c++) begin
            run_burst(c, int'($urandom % 256));
            drain_stream();
        end
    endtask

    // each start lands on the first idle cycle, so earlier words are still in flight
    task automatic test_back_to_back();
        run_burst(1, int'($urandom % 64));
        run_burst(2, int'($urandom % 64));
        run_burst(2, int'($urandom % 64));  // repeat must restart at address 0
        drain_stream();
    endtask

    task automatic test_refresh();
        run_refresh();
        run_burst(3, 20);
        drain_stream();
    endtask

    initial begin
        void'($urandom(96012));
        busy_from = 0;
        busy_to   = -1;
        ref_from  = 0;
        ref_to    = -1;
        for (int c = 0; c < NUM_CHN; c++) begin
            run_from[c] = 0;
            run_to[c]   = -1;
        end
        rst         = 1'b1;
        host_we     = 1'b0;
        host_chn    = '0;
        host_waddr  = '0;
        host_wdata  = '0;
        cmd_start   = 1'b0;
        cmd_chn     = '0;
        cmd_len     = '0;
        cmd_refresh = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single_burst();
        test_all_channels();
        test_back_to_back();
        test_refresh();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/mcont_types_pkg.sv
hdl/mcont_seq_pkg.sv
hdl/mcont_from_chnbuf_reg.sv
hdl/chn_write_buffer.sv
hdl/mcont_write_sequencer.sv
hdl/mcont_wdata_gather.sv
hdl/mcont_wpath_top.sv
verif/mcont_wpath_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the write-data path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module mcont_wpath_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vmcont_wpath_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
